//--- src/sio_bridge_cfg.svh
/*
 * Build-time sizes for the disk bridge and the mouse paddle emulation
 */

`ifndef SIO_BRIDGE_CFG_SVH
`define SIO_BRIDGE_CFG_SVH

// ======================================================================
// Disk bridge
// ======================================================================

// Byte index inside one 512-byte sector
`define SECTOR_ADDR_W 9

// Host storage slots, one request bit each
`define NUM_DRIVES 4

// ======================================================================
// Mouse to paddle
// ======================================================================

// Largest movement taken from a single packet
`define MOUSE_STEP_MAX 10

// Paddle position range
`define AXIS_MAX 127
`define AXIS_MIN (-128)

`endif

//--- src/disk_pkg.sv
/*
 * Types shared by the disk request controller, the sector buffer and the top
 */

`include "sio_bridge_cfg.svh"

package disk_pkg;

	typedef logic [`SECTOR_ADDR_W-1:0] sector_addr_t;
	typedef logic [7:0]                sector_byte_t;
	typedef logic [31:0]               lba_t;
	typedef logic [31:0]               file_size_t;
	typedef logic [`NUM_DRIVES-1:0]    drive_mask_t;
	typedef logic [2:0]                drive_num_t;

	// Levels from the I/O processor, bit 0 is lba_sel
	typedef struct packed {
		drive_num_t drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} zpu_ctrl_t;

	typedef struct packed {
		logic io_wr;
		logic data_wr;
		logic data_rd;
	} zpu_strobe_t;

	// Status byte as the I/O processor reads it, io_done in bit 0
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} disk_status_t;

	typedef struct packed {
		drive_mask_t mounted;
		logic        readonly;
		logic [1:0]  filetype;
		file_size_t  size;
	} mount_info_t;

endpackage

//--- src/axis_pkg.sv
/*
 * Types for PS/2 mouse packets, joystick words and paddle positions
 */

package axis_pkg;

	typedef logic signed [7:0] axis_t;
	typedef logic signed [8:0] axis_acc_t;
	typedef logic [13:0]       joy_digital_t;

	// Flags hold Y sign in bit 5, X sign in bit 4, buttons in bits 1:0
	typedef struct packed {
		logic       stb;
		logic [7:0] y_move;
		logic [7:0] x_move;
		logic [7:0] flags;
	} ps2_mouse_t;

	// X in the low byte
	typedef struct packed {
		axis_t y;
		axis_t x;
	} joy_analog_t;

endpackage

//--- src/sector_buffer.sv
/*
 * Dual-port sector RAM, one registered read-first output per port
 */

`timescale 1ns/1ps

`include "sio_bridge_cfg.svh"

module sector_buffer (
	input  logic                  clk_sys,

	// Port A
	input  disk_pkg::sector_addr_t a_addr_i,
	input  disk_pkg::sector_byte_t a_wdata_i,
	input  logic                   a_we_i,
	output disk_pkg::sector_byte_t a_rdata_o,

	// Port B
	input  disk_pkg::sector_addr_t b_addr_i,
	input  disk_pkg::sector_byte_t b_wdata_i,
	input  logic                   b_we_i,
	output disk_pkg::sector_byte_t b_rdata_o
);

	import disk_pkg::*;

	localparam int DEPTH = 1 << `SECTOR_ADDR_W;

	sector_byte_t mem [DEPTH];

	// Both ports share the array, so they live in one process
	always_ff @(posedge clk_sys) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end

		// Old contents come out on a write to the same address
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

//--- src/disk_request_ctrl.sv
/*
 * I/O processor register side of the disk bridge: buffer pointer,
 * LBA latch, block requests, completion flag and mount reporting
 */

`timescale 1ns/1ps

module disk_request_ctrl (
	input  logic                   clk_sys,
	input  logic                   areset,

	// I/O processor
	input  disk_pkg::zpu_ctrl_t    zpu_ctrl_i,
	input  disk_pkg::zpu_strobe_t  zpu_strobe_i,
	input  logic [31:0]            zpu_wdata_i,
	output disk_pkg::disk_status_t zpu_status_o,
	output logic [31:0]            zpu_rdata_o,

	// Host storage channel
	output disk_pkg::lba_t         sd_lba_o,
	output disk_pkg::drive_mask_t  sd_rd_o,
	output disk_pkg::drive_mask_t  sd_wr_o,
	input  disk_pkg::drive_mask_t  sd_ack_i,
	input  disk_pkg::mount_info_t  mount_i,

	// Sector buffer port
	output disk_pkg::sector_addr_t buf_addr_o,
	output disk_pkg::sector_byte_t buf_wdata_o,
	output logic                   buf_we_o,
	input  disk_pkg::sector_byte_t buf_rdata_i
);

	import disk_pkg::*;

	zpu_strobe_t stb_q1;
	zpu_strobe_t stb_q2;
	logic        blk_rd_q1;
	logic        blk_rd_q2;
	logic        blk_wr_q1;
	logic        blk_wr_q2;
	logic        ack_q1;
	logic        ack_q2;
	logic        mnt_q1;
	logic        mnt_q2;
	mount_info_t mount_q;

	sector_addr_t ptr;
	logic         io_done;
	logic         mounted;
	logic [2:0]   fileno;
	logic [1:0]   filetype;
	logic         readonly;
	file_size_t   file_size;

	logic       wr_rise;
	logic       rd_fall;
	logic       blk_rd_rise;
	logic       blk_wr_rise;
	logic       ack_fall;
	logic       mnt_rise;
	logic [1:0] slot;

	// ==================================================================
	// Edge detection, every input level goes through two stages
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q1    <= '0;
			stb_q2    <= '0;
			blk_rd_q1 <= 1'b0;
			blk_rd_q2 <= 1'b0;
			blk_wr_q1 <= 1'b0;
			blk_wr_q2 <= 1'b0;
			ack_q1    <= 1'b0;
			ack_q2    <= 1'b0;
			mnt_q1    <= 1'b0;
			mnt_q2    <= 1'b0;
		end else begin
			stb_q1    <= zpu_strobe_i;
			stb_q2    <= stb_q1;
			blk_rd_q1 <= zpu_ctrl_i.block_rd;
			blk_rd_q2 <= blk_rd_q1;
			blk_wr_q1 <= zpu_ctrl_i.block_wr;
			blk_wr_q2 <= blk_wr_q1;
			ack_q1    <= |sd_ack_i;
			ack_q2    <= ack_q1;
			mnt_q1    <= |mount_i.mounted;
			mnt_q2    <= mnt_q1;
		end
	end

	assign wr_rise     = stb_q1.data_wr & ~stb_q2.data_wr;
	assign rd_fall     = ~stb_q1.data_rd & stb_q2.data_rd;
	assign blk_rd_rise = blk_rd_q1 & ~blk_rd_q2;
	assign blk_wr_rise = blk_wr_q1 & ~blk_wr_q2;
	assign ack_fall    = ~ack_q1 & ack_q2;
	assign mnt_rise    = mnt_q1 & ~mnt_q2;

	// Drive numbers 0,1,4,5 map onto slots 0..3
	assign slot = {zpu_ctrl_i.drv_num[2], zpu_ctrl_i.drv_num[0]};

	// ==================================================================
	// Buffer pointer and byte writes
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr      <= '0;
			buf_we_o <= 1'b0;
		end else begin
			buf_we_o <= wr_rise & ~zpu_ctrl_i.lba_sel;
			// Step past the byte just written or just read
			if (buf_we_o || rd_fall) begin
				ptr <= ptr + 1'b1;
			end
			if (zpu_strobe_i.io_wr) begin
				ptr <= '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			if (zpu_ctrl_i.lba_sel) begin
				sd_lba_o <= zpu_wdata_i;
			end else begin
				buf_wdata_o <= zpu_wdata_i[7:0];
			end
		end
		mount_q <= mount_i;
		if (mnt_rise) begin
			file_size <= mount_q.size;
		end
	end

	// ==================================================================
	// Block requests and completion
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd_o <= '0;
			sd_wr_o <= '0;
			io_done <= 1'b0;
		end else begin
			if (blk_rd_rise) begin
				io_done       <= 1'b0;
				sd_rd_o[slot] <= 1'b1;
			end
			if (blk_wr_rise) begin
				io_done       <= 1'b0;
				sd_wr_o[slot] <= 1'b1;
			end
			// Host has taken the request
			if (|sd_ack_i) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end
			if (ack_fall) begin
				io_done <= 1'b1;
			end
		end
	end

	// Mount events, higher slots win if several arrive together
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted  <= 1'b0;
			fileno   <= '0;
			filetype <= '0;
			readonly <= 1'b0;
		end else if (mnt_rise) begin
			if (mount_q.mounted[3]) begin
				fileno <= 3'd5;
			end else if (mount_q.mounted[2]) begin
				fileno <= 3'd4;
			end else if (mount_q.mounted[1]) begin
				fileno <= 3'd1;
			end else begin
				fileno <= 3'd0;
			end
			filetype <= mount_q.filetype;
			readonly <= mount_q.readonly | mount_q.mounted[2] | mount_q.mounted[3];
			mounted  <= ~mounted;
		end
	end

	always_comb begin
		zpu_status_o.readonly = readonly;
		zpu_status_o.filetype = filetype;
		zpu_status_o.fileno   = fileno;
		zpu_status_o.mounted  = mounted;
		zpu_status_o.io_done  = io_done;
	end

	assign zpu_rdata_o = zpu_ctrl_i.lba_sel ? file_size : 32'(buf_rdata_i);
	assign buf_addr_o  = ptr;

	// Only one transfer direction may be pending toward the host
	assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_rd_o) && (|sd_wr_o)));

	// An acknowledge from the host retires every pending request
	assert property (@(posedge clk_sys) disable iff (areset)
		(|sd_ack_i) |=> (sd_rd_o == '0) && (sd_wr_o == '0));

endmodule

//--- src/mouse_axis_emu.sv
/*
 * PS/2 mouse to paddle position emulation with joystick fallback
 */

`timescale 1ns/1ps

`include "sio_bridge_cfg.svh"

module mouse_axis_emu (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  axis_pkg::ps2_mouse_t   mouse_i,
	input  logic                   invert_y_i,
	input  axis_pkg::joy_analog_t  joy_analog_i,
	input  axis_pkg::joy_digital_t joy_digital_i,
	input  logic                   cpu_halt_i,
	output axis_pkg::axis_t        axis_x_o,
	output axis_pkg::axis_t        axis_y_o,
	output axis_pkg::joy_digital_t joy_digital_o
);

	import axis_pkg::*;

	localparam axis_acc_t STEP_MAX = axis_acc_t'(`MOUSE_STEP_MAX);
	localparam axis_acc_t POS_MAX  = axis_acc_t'(`AXIS_MAX);
	localparam axis_acc_t POS_MIN  = axis_acc_t'(`AXIS_MIN);

	function automatic axis_acc_t clamp(axis_acc_t v, axis_acc_t lo, axis_acc_t hi);
		if (v > hi) begin
			return hi;
		end
		if (v < lo) begin
			return lo;
		end
		return v;
	endfunction

	ps2_mouse_t mouse_q;
	logic       stb_q1;
	logic       stb_q2;
	logic       emu_on;
	axis_acc_t  pos_x;
	axis_acc_t  pos_y;
	axis_acc_t  step_x;
	axis_acc_t  step_y;
	axis_acc_t  next_x;
	axis_acc_t  next_y;
	logic       emu_off;

	// 9-bit movement, sign from the flag byte
	assign step_x = clamp(axis_acc_t'({mouse_q.flags[4], mouse_q.x_move}), -STEP_MAX, STEP_MAX);
	assign step_y = clamp(axis_acc_t'({mouse_q.flags[5], mouse_q.y_move}), -STEP_MAX, STEP_MAX);
	assign next_x = clamp(pos_x + step_x, POS_MIN, POS_MAX);
	assign next_y = clamp(invert_y_i ? pos_y - step_y : pos_y + step_y, POS_MIN, POS_MAX);

	// Real analog stick or halted CPU hands control back
	assign emu_off = (joy_analog_i != '0) || cpu_halt_i;

	always_ff @(posedge clk_sys) begin
		mouse_q <= mouse_i;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q1 <= 1'b0;
			stb_q2 <= 1'b0;
			emu_on <= 1'b0;
			pos_x  <= '0;
			pos_y  <= '0;
		end else begin
			stb_q1 <= mouse_i.stb;
			stb_q2 <= stb_q1;
			if (emu_off) begin
				emu_on <= 1'b0;
				pos_x  <= '0;
				pos_y  <= '0;
			end else if (stb_q1 != stb_q2) begin
				emu_on <= 1'b1;
				pos_x  <= next_x;
				pos_y  <= next_y;
			end
		end
	end

	assign axis_x_o = emu_on ? axis_t'(pos_x[7:0]) : joy_analog_i.x;
	assign axis_y_o = emu_on ? axis_t'(pos_y[7:0]) : joy_analog_i.y;

	// Mouse buttons stand in for the fire bits
	assign joy_digital_o = emu_on ?
		{joy_digital_i[13:9], mouse_i.flags[1:0], joy_digital_i[6:0]} : joy_digital_i;

	assert property (@(posedge clk_sys) disable iff (areset)
		(pos_x >= POS_MIN) && (pos_x <= POS_MAX) && (pos_y >= POS_MIN) && (pos_y <= POS_MAX));

endmodule

//--- src/sio_bridge_top.sv
/*
 * Disk bridge with its sector buffer, plus the mouse paddle emulation
 */

`timescale 1ns/1ps

module sio_bridge_top (
	input  logic                   clk_sys,
	input  logic                   areset,

	// I/O processor
	input  disk_pkg::zpu_ctrl_t    zpu_ctrl_i,
	input  disk_pkg::zpu_strobe_t  zpu_strobe_i,
	input  logic [31:0]            zpu_wdata_i,
	output disk_pkg::disk_status_t zpu_status_o,
	output logic [31:0]            zpu_rdata_o,

	// Host storage channel
	output disk_pkg::lba_t         sd_lba_o,
	output disk_pkg::drive_mask_t  sd_rd_o,
	output disk_pkg::drive_mask_t  sd_wr_o,
	input  disk_pkg::drive_mask_t  sd_ack_i,
	input  disk_pkg::sector_addr_t sd_buff_addr_i,
	input  disk_pkg::sector_byte_t sd_buff_dout_i,
	input  logic                   sd_buff_wr_i,
	output disk_pkg::sector_byte_t sd_buff_din_o,
	input  disk_pkg::mount_info_t  mount_i,

	// Mouse and joystick
	input  axis_pkg::ps2_mouse_t   mouse_i,
	input  logic                   invert_y_i,
	input  axis_pkg::joy_analog_t  joy_analog_i,
	input  axis_pkg::joy_digital_t joy_digital_i,
	input  logic                   cpu_halt_i,
	output axis_pkg::axis_t        axis_x_o,
	output axis_pkg::axis_t        axis_y_o,
	output axis_pkg::joy_digital_t joy_digital_o
);

	import disk_pkg::*;

	sector_addr_t ctrl_buf_addr;
	sector_byte_t ctrl_buf_wdata;
	sector_byte_t ctrl_buf_rdata;
	logic         ctrl_buf_we;

	disk_request_ctrl u_disk_request_ctrl (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.zpu_ctrl_i   (zpu_ctrl_i),
		.zpu_strobe_i (zpu_strobe_i),
		.zpu_wdata_i  (zpu_wdata_i),
		.zpu_status_o (zpu_status_o),
		.zpu_rdata_o  (zpu_rdata_o),
		.sd_lba_o     (sd_lba_o),
		.sd_rd_o      (sd_rd_o),
		.sd_wr_o      (sd_wr_o),
		.sd_ack_i     (sd_ack_i),
		.mount_i      (mount_i),
		.buf_addr_o   (ctrl_buf_addr),
		.buf_wdata_o  (ctrl_buf_wdata),
		.buf_we_o     (ctrl_buf_we),
		.buf_rdata_i  (ctrl_buf_rdata)
	);

	// Port A faces the host, port B the controller
	sector_buffer u_sector_buffer (
		.clk_sys   (clk_sys),
		.a_addr_i  (sd_buff_addr_i),
		.a_wdata_i (sd_buff_dout_i),
		.a_we_i    (sd_buff_wr_i),
		.a_rdata_o (sd_buff_din_o),
		.b_addr_i  (ctrl_buf_addr),
		.b_wdata_i (ctrl_buf_wdata),
		.b_we_i    (ctrl_buf_we),
		.b_rdata_o (ctrl_buf_rdata)
	);

	mouse_axis_emu u_mouse_axis_emu (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.mouse_i       (mouse_i),
		.invert_y_i    (invert_y_i),
		.joy_analog_i  (joy_analog_i),
		.joy_digital_i (joy_digital_i),
		.cpu_halt_i    (cpu_halt_i),
		.axis_x_o      (axis_x_o),
		.axis_y_o      (axis_y_o),
		.joy_digital_o (joy_digital_o)
	);

endmodule

//--- test/tb_sio_bridge.sv
/*
 * Directed testbench for the disk bridge and the mouse paddle emulation
 */

`timescale 1ns/1ps

`include "sio_bridge_cfg.svh"

module tb_sio_bridge;

	import disk_pkg::*;
	import axis_pkg::*;

	localparam int TIMEOUT = 50;
	localparam int SECTOR  = 1 << `SECTOR_ADDR_W;

	// Conditions a wait loop can look for
	localparam int W_REQ     = 0;
	localparam int W_CLEAR   = 1;
	localparam int W_DONE    = 2;
	localparam int W_MOUNT   = 3;
	localparam int W_EMU_OFF = 4;

	logic         clk_sys;
	logic         areset;
	zpu_ctrl_t    zpu_ctrl;
	zpu_strobe_t  zpu_strobe;
	logic [31:0]  zpu_wdata;
	disk_status_t zpu_status;
	logic [31:0]  zpu_rdata;
	lba_t         sd_lba;
	drive_mask_t  sd_rd;
	drive_mask_t  sd_wr;
	drive_mask_t  sd_ack;
	sector_addr_t sd_buff_addr;
	sector_byte_t sd_buff_dout;
	logic         sd_buff_wr;
	sector_byte_t sd_buff_din;
	mount_info_t  mount_info;
	ps2_mouse_t   mouse;
	logic         invert_y;
	joy_analog_t  joy_analog;
	joy_digital_t joy_digital_in;
	logic         cpu_halt;
	axis_t        axis_x;
	axis_t        axis_y;
	joy_digital_t joy_digital_out;

	disk_status_t exp_status;
	sector_byte_t sector_data [SECTOR];
	integer       seed;
	int           model_x;
	int           model_y;

	sio_bridge_top u_sio_bridge_top (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.zpu_ctrl_i     (zpu_ctrl),
		.zpu_strobe_i   (zpu_strobe),
		.zpu_wdata_i    (zpu_wdata),
		.zpu_status_o   (zpu_status),
		.zpu_rdata_o    (zpu_rdata),
		.sd_lba_o       (sd_lba),
		.sd_rd_o        (sd_rd),
		.sd_wr_o        (sd_wr),
		.sd_ack_i       (sd_ack),
		.sd_buff_addr_i (sd_buff_addr),
		.sd_buff_dout_i (sd_buff_dout),
		.sd_buff_wr_i   (sd_buff_wr),
		.sd_buff_din_o  (sd_buff_din),
		.mount_i        (mount_info),
		.mouse_i        (mouse),
		.invert_y_i     (invert_y),
		.joy_analog_i   (joy_analog),
		.joy_digital_i  (joy_digital_in),
		.cpu_halt_i     (cpu_halt),
		.axis_x_o       (axis_x),
		.axis_y_o       (axis_y),
		.joy_digital_o  (joy_digital_out)
	);

	always #50 clk_sys = ~clk_sys;

	// ======================================================================
	// Common helpers
	// ======================================================================

	// Inputs change and outputs are sampled 10 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_status(input disk_status_t got, input disk_status_t exp,
		input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_lba(input lba_t got, input lba_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_mask(input drive_mask_t got, input drive_mask_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_byte(input sector_byte_t got, input sector_byte_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_axis(input axis_t got, input axis_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_joy(input joy_digital_t got, input joy_digital_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	function automatic bit cond_met(input int kind);
		case (kind)
			W_REQ:     return (sd_rd | sd_wr) != '0;
			W_CLEAR:   return (sd_rd | sd_wr) == '0;
			W_DONE:    return zpu_status.io_done === 1'b1;
			W_MOUNT:   return zpu_status.mounted === exp_status.mounted;
			default:   return joy_digital_out === joy_digital_in;
		endcase
	endfunction

	task automatic wait_for(input int kind, input string what);
		int n;
		n = 0;
		while (!cond_met(kind)) begin
			if (n == TIMEOUT) begin
				stop_on_error($sformatf("Timed out waiting for %s", what));
			end
			tick();
			n++;
		end
	endtask

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v > hi) begin
			return hi;
		end
		return (v < lo) ? lo : v;
	endfunction

	// ======================================================================
	// I/O processor and host actions
	// ======================================================================

	// Levels stay put until the edge that acts on the strobe has passed
	task automatic write_word(input logic lba_sel, input logic [31:0] data);
		zpu_ctrl.lba_sel   = lba_sel;
		zpu_wdata          = data;
		zpu_strobe.data_wr = 1'b1;
		tick();
		tick();
		zpu_strobe.data_wr = 1'b0;
		tick();
		tick();
	endtask

	task automatic rewind_pointer();
		zpu_strobe.io_wr = 1'b1;
		tick();
		zpu_strobe.io_wr = 1'b0;
		tick();
		tick();
	endtask

	task automatic request_block(input logic is_write, input drive_num_t drv);
		zpu_ctrl.drv_num  = drv;
		zpu_ctrl.block_rd = ~is_write;
		zpu_ctrl.block_wr = is_write;
		wait_for(W_REQ, "a block request");
		zpu_ctrl.block_rd = 1'b0;
		zpu_ctrl.block_wr = 1'b0;
	endtask

	task automatic mount_image(input drive_mask_t slot_bit, input logic ro,
		input logic [1:0] ftype, input file_size_t size);
		mount_info.mounted  = slot_bit;
		mount_info.readonly = ro;
		mount_info.filetype = ftype;
		mount_info.size     = size;
		exp_status.mounted  = ~exp_status.mounted;
		wait_for(W_MOUNT, "the mounted flag to toggle");
		mount_info.mounted = '0;
		tick();
		tick();
	endtask

	// Positions settle two cycles after the stb toggle
	task automatic send_packet(input int dx, input int dy, input logic [1:0] buttons);
		joy_digital_t exp_joy;
		mouse.x_move     = dx[7:0];
		mouse.y_move     = dy[7:0];
		mouse.flags      = '0;
		mouse.flags[4]   = dx[8];
		mouse.flags[5]   = dy[8];
		mouse.flags[1:0] = buttons;
		mouse.stb        = ~mouse.stb;
		model_x = clamp_int(model_x + clamp_int(dx, -`MOUSE_STEP_MAX, `MOUSE_STEP_MAX),
			`AXIS_MIN, `AXIS_MAX);
		dy = clamp_int(dy, -`MOUSE_STEP_MAX, `MOUSE_STEP_MAX);
		model_y = clamp_int(invert_y ? model_y - dy : model_y + dy, `AXIS_MIN, `AXIS_MAX);
		exp_joy = joy_digital_in;
		exp_joy[8:7] = buttons;
		tick();
		tick();
		check_axis(axis_x, axis_t'(model_x), "mouse X position");
		check_axis(axis_y, axis_t'(model_y), "mouse Y position");
		check_joy(joy_digital_out, exp_joy, "joystick with mouse buttons");
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic test_mount();
		mount_image(4'b0100, 1'b0, 2'd2, 32'h0001_6810);
		exp_status.fileno   = 3'd4;
		exp_status.readonly = 1'b1;
		exp_status.filetype = 2'd2;
		check_status(zpu_status, exp_status, "status after slot 2 mount");
		zpu_ctrl.lba_sel = 1'b1;
		tick();
		check_lba(zpu_rdata, 32'h0001_6810, "image size on read word");
		zpu_ctrl.lba_sel = 1'b0;
		mount_image(4'b0010, 1'b0, 2'd1, 32'h0000_2000);
		exp_status.fileno   = 3'd1;
		exp_status.readonly = 1'b0;
		exp_status.filetype = 2'd1;
		check_status(zpu_status, exp_status, "status after slot 1 mount");
	endtask

	task automatic test_read_request();
		write_word(1'b1, 32'h0012_3456);
		zpu_ctrl.lba_sel = 1'b0;
		check_lba(sd_lba, 32'h0012_3456, "latched LBA");
		request_block(1'b0, 3'd4);
		check_mask(sd_rd, 4'b0100, "read request for drive 4");
		check_mask(sd_wr, '0, "write request during read");
		check_status(zpu_status, exp_status, "status with read pending");
		sd_ack = 4'b0100;
		wait_for(W_CLEAR, "the request bits to clear");
		sd_ack = '0;
		wait_for(W_DONE, "io_done after the read");
		exp_status.io_done = 1'b1;
		check_status(zpu_status, exp_status, "status after the read");
	endtask

	task automatic test_sector_in();
		int i;
		request_block(1'b0, 3'd0);
		check_mask(sd_rd, 4'b0001, "read request for drive 0");
		// A new request drops the completion flag left by the last one
		exp_status.io_done = 1'b0;
		check_status(zpu_status, exp_status, "status with sector read pending");
		sd_ack = 4'b0001;
		for (i = 0; i < SECTOR; i++) begin
			sector_data[i] = sector_byte_t'($random(seed));
			sd_buff_addr   = sector_addr_t'(i);
			sd_buff_dout   = sector_data[i];
			sd_buff_wr     = 1'b1;
			tick();
		end
		sd_buff_wr = 1'b0;
		sd_ack     = '0;
		wait_for(W_DONE, "io_done after the sector came in");
		exp_status.io_done = 1'b1;
		rewind_pointer();
		for (i = 0; i < SECTOR; i++) begin
			check_byte(zpu_rdata[7:0], sector_data[i], $sformatf("read byte %0d", i));
			zpu_strobe.data_rd = 1'b1;
			tick();
			zpu_strobe.data_rd = 1'b0;
			tick();
			tick();
			tick();
		end
	endtask

	task automatic test_sector_out();
		int          i;
		logic [31:0] word;
		rewind_pointer();
		for (i = 0; i < SECTOR; i++) begin
			word           = $random(seed);
			sector_data[i] = word[7:0];
			write_word(1'b0, word);
		end
		request_block(1'b1, 3'd1);
		check_mask(sd_wr, 4'b0010, "write request for drive 1");
		check_mask(sd_rd, '0, "read request during write");
		exp_status.io_done = 1'b0;
		check_status(zpu_status, exp_status, "status with sector write pending");
		sd_ack = 4'b0010;
		for (i = 0; i < SECTOR; i++) begin
			sd_buff_addr = sector_addr_t'(i);
			tick();
			check_byte(sd_buff_din, sector_data[i], $sformatf("host byte %0d", i));
		end
		sd_ack = '0;
		wait_for(W_DONE, "io_done after the sector went out");
		exp_status.io_done = 1'b1;
		check_status(zpu_status, exp_status, "status after the sector went out");
	endtask

	task automatic test_mouse();
		int k;
		check_axis(axis_x, '0, "X with emulation off");
		check_joy(joy_digital_out, joy_digital_in, "joystick passthrough");
		// Large moves run both axes into their limits
		for (k = 0; k < 14; k++) begin
			send_packet(50, -50, 2'b11);
		end
		send_packet(-3, 200, 2'b01);
		invert_y = 1'b1;
		send_packet(7, 4, 2'b10);
		send_packet(-120, -90, 2'b10);
		joy_analog.x = -8'sd16;
		joy_analog.y = 8'sd5;
		wait_for(W_EMU_OFF, "the analog stick to take over");
		check_axis(axis_x, -8'sd16, "analog X");
		check_axis(axis_y, 8'sd5, "analog Y");
		joy_analog = '0;
		tick();
		check_axis(axis_x, '0, "X after takeover");
		check_axis(axis_y, '0, "Y after takeover");
		model_x = 0;
		model_y = 0;
		send_packet(9, 9, 2'b01);
		// A halted CPU also hands control back and clears the positions
		cpu_halt = 1'b1;
		wait_for(W_EMU_OFF, "the CPU halt to stop the emulation");
		cpu_halt = 1'b0;
		model_x = 0;
		model_y = 0;
		send_packet(-4, 6, 2'b10);
	endtask

	initial begin
		seed           = 62;
		clk_sys        = 1'b0;
		areset         = 1'b1;
		zpu_ctrl       = '0;
		zpu_strobe     = '0;
		zpu_wdata      = '0;
		sd_ack         = '0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_buff_wr     = 1'b0;
		mount_info     = '0;
		mouse          = '0;
		invert_y       = 1'b0;
		joy_analog     = '0;
		joy_digital_in = 14'h2A55;
		cpu_halt       = 1'b0;
		exp_status     = '0;
		model_x        = 0;
		model_y        = 0;
		repeat (5) tick();
		areset = 1'b0;
		tick();
		check_status(zpu_status, exp_status, "status after reset");
		check_mask(sd_rd | sd_wr, '0, "requests after reset");
		test_mount();
		test_read_request();
		test_sector_in();
		test_sector_out();
		test_mouse();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- list.f
+incdir+src
src/disk_pkg.sv
src/axis_pkg.sv
src/sector_buffer.sv
src/disk_request_ctrl.sv
src/mouse_axis_emu.sv
src/sio_bridge_top.sv
test/tb_sio_bridge.sv

//--- Bender.yml
package:
  name: sio_bridge

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/disk_pkg.sv
      - src/axis_pkg.sv
      - src/sector_buffer.sv
      - src/disk_request_ctrl.sv
      - src/mouse_axis_emu.sv
      - src/sio_bridge_top.sv
      - target: test
        include_dirs:
          - src
        files:
          - test/tb_sio_bridge.sv
